//--- design/nn_cfg_pkg.sv
package nn_cfg_pkg;

	// Fixed-point sample format
	localparam int sample_width = 16;

	typedef logic signed [sample_width-1:0] sample_t;

	// Vector lengths through the network
	localparam int in_len  = 4;
	localparam int hid_len = 8;
	localparam int out_len = 12;

endpackage

//--- design/nn_weights_pkg.sv
package nn_weights_pkg;

	import nn_cfg_pkg::*;

	// One row per hidden output of layer 1
	localparam sample_t w1 [hid_len][in_len] = '{
		'{ 5, -1, -6,  5},
		'{-4,  6, -4,  3},
		'{ 2, -7,  4, -4},
		'{ 0, -5,  4, -3},
		'{-6,  1, -6,  4},
		'{ 2, -3,  3, -4},
		'{ 4, -3, -1,  6},
		'{ 1,  7,  1, -2}
	};

	// One row per network output of layer 2
	localparam sample_t w2 [out_len][hid_len] = '{
		'{-2,  4, -5, -8,  5,  7, -3,  7},
		'{ 1, -1,  4, -3,  4, -5, -5, -8},
		'{-6, -1,  3,  2,  2, -1, -8, -3},
		'{ 4,  3,  1, -3,  3, -6,  4, -7},
		'{ 6,  7, -6,  3,  7, -1,  3,  0},
		'{ 6, -1,  5,  2,  2, -7,  3,  4},
		'{ 0, -2, -1, -5,  6, -1,  0,  2},
		'{-6, -7, -8,  5, -5,  4,  7, -6},
		'{ 3, -7,  5,  2,  0,  0, -6, -2},
		'{ 7, -8, -8,  2, -7,  3, -2,  1},
		'{-6,  5,  4, -8, -4, -4,  2, -1},
		'{-3,  2, -4,  1, -2, -5,  3, -6}
	};

	function automatic sample_t weight(input int layer, input int row, input int col);
		sample_t w;
		w = '0;
		if (layer == 1 && row < hid_len && col < in_len)
			w = w1[row][col];
		else if (layer == 2 && row < out_len && col < hid_len)
			w = w2[row][col];
		return w;
	endfunction

endpackage

//--- design/layer_control.sv
`timescale 1ns/1ps

module layer_control #(
	parameter int n_in  = 4,
	parameter int m_out = 8
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     in_valid,
	input  logic                     out_ready,
	output logic                     in_ready,
	output logic                     out_valid,
	output logic                     x_wr,
	output logic [$clog2(n_in)-1:0]  x_addr,
	output logic                     acc_clear,
	output logic                     acc_en,
	output logic [$clog2(n_in)-1:0]  w_col,
	output logic [$clog2(m_out)-1:0] out_sel
);

	localparam int x_w   = $clog2(n_in);
	localparam int sel_w = $clog2(m_out);
	// Counter must reach n_in+1 in compute and m_out-1 in drain
	localparam int cnt_w = $clog2((n_in + 2 > m_out) ? n_in + 2 : m_out);

	typedef enum logic [1:0] {
		st_load,
		st_compute,
		st_drain
	} state_t;

	state_t           state;
	logic [cnt_w-1:0] cnt;

	assign in_ready  = (state == st_load);
	assign out_valid = (state == st_drain);

	assign x_wr   = in_ready && in_valid;
	assign x_addr = x_w'(cnt);

	// Compute cycle 0 clears, cycles 1..n_in accumulate
	assign acc_clear = (state == st_compute) && (cnt == '0);
	assign acc_en    = (state == st_compute) && (cnt != '0) && (cnt <= cnt_w'(n_in));
	assign w_col     = x_w'(cnt - cnt_w'(1));

	assign out_sel = sel_w'(cnt);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_load;
			cnt   <= '0;
		end else begin
			case (state)
				st_load: begin
					if (in_valid) begin
						if (cnt == cnt_w'(n_in - 1)) begin
							state <= st_compute;
							cnt   <= '0;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
				end
				st_compute: begin
					// Last cycle loads the ReLU results
					if (cnt == cnt_w'(n_in + 1)) begin
						state <= st_drain;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				st_drain: begin
					if (out_ready) begin
						if (cnt == cnt_w'(m_out - 1)) begin
							state <= st_load;
							cnt   <= '0;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
				end
				default: begin
					state <= st_load;
					cnt   <= '0;
				end
			endcase
		end
	end

endmodule

//--- design/mac_array.sv
`timescale 1ns/1ps

module mac_array #(
	parameter int n_in     = 4,
	parameter int m_out    = 8,
	parameter int layer_id = 1
) (
	input  logic                     clk,
	input  nn_cfg_pkg::sample_t      in_data,
	input  logic                     x_wr,
	input  logic [$clog2(n_in)-1:0]  x_addr,
	input  logic                     acc_clear,
	input  logic                     acc_en,
	input  logic [$clog2(n_in)-1:0]  w_col,
	input  logic [$clog2(m_out)-1:0] out_sel,
	output nn_cfg_pkg::sample_t      out_data
);

	import nn_cfg_pkg::*;
	import nn_weights_pkg::*;

	sample_t x    [n_in];
	sample_t acc  [m_out];
	sample_t prod [m_out];
	sample_t res  [m_out];

	logic acc_en_q;
	logic res_load;

	// Input vector store
	always_ff @(posedge clk) begin
		if (x_wr)
			x[x_addr] <= in_data;
	end

	// One 16-bit truncated product per lane
	always_comb begin
		for (int i = 0; i < m_out; i++)
			prod[i] = x[w_col] * weight(layer_id, i, int'(w_col));
	end

	// Results load on the cycle after the last accumulate
	always_ff @(posedge clk) begin
		acc_en_q <= acc_en;
	end

	assign res_load = acc_en_q && !acc_en;

	always_ff @(posedge clk) begin
		for (int i = 0; i < m_out; i++) begin
			if (acc_clear)
				acc[i] <= '0;
			else if (acc_en)
				acc[i] <= acc[i] + prod[i];

			// ReLU
			if (res_load)
				res[i] <= acc[i][sample_width-1] ? '0 : acc[i];
		end
	end

	assign out_data = res[out_sel];

endmodule

//--- design/fc_layer.sv
`timescale 1ns/1ps

module fc_layer #(
	parameter int n_in     = 4,
	parameter int m_out    = 8,
	parameter int layer_id = 1
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               in_valid,
	output logic               in_ready,
	input  nn_cfg_pkg::sample_t in_data,
	output logic               out_valid,
	input  logic               out_ready,
	output nn_cfg_pkg::sample_t out_data
);

	localparam int x_w   = $clog2(n_in);
	localparam int sel_w = $clog2(m_out);

	logic             x_wr;
	logic [x_w-1:0]   x_addr;
	logic             acc_clear;
	logic             acc_en;
	logic [x_w-1:0]   w_col;
	logic [sel_w-1:0] out_sel;

	layer_control #(.n_in(n_in), .m_out(m_out)) i_control (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.out_ready (out_ready),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.x_wr      (x_wr),
		.x_addr    (x_addr),
		.acc_clear (acc_clear),
		.acc_en    (acc_en),
		.w_col     (w_col),
		.out_sel   (out_sel)
	);

	mac_array #(.n_in(n_in), .m_out(m_out), .layer_id(layer_id)) i_mac (
		.clk       (clk),
		.in_data   (in_data),
		.x_wr      (x_wr),
		.x_addr    (x_addr),
		.acc_clear (acc_clear),
		.acc_en    (acc_en),
		.w_col     (w_col),
		.out_sel   (out_sel),
		.out_data  (out_data)
	);

endmodule

//--- design/nn_top.sv
`timescale 1ns/1ps

module nn_top (
	input  logic               clk,
	input  logic               reset,
	input  logic               in_valid,
	output logic               in_ready,
	input  nn_cfg_pkg::sample_t in_data,
	output logic               out_valid,
	input  logic               out_ready,
	output nn_cfg_pkg::sample_t out_data
);

	import nn_cfg_pkg::*;

	// Hidden vector stream between the layers
	logic    l1_valid;
	logic    l1_ready;
	sample_t l1_data;

	fc_layer #(.n_in(in_len), .m_out(hid_len), .layer_id(1)) i_layer_1 (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_data),
		.out_valid (l1_valid),
		.out_ready (l1_ready),
		.out_data  (l1_data)
	);

	fc_layer #(.n_in(hid_len), .m_out(out_len), .layer_id(2)) i_layer_2 (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (l1_valid),
		.in_ready  (l1_ready),
		.in_data   (l1_data),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data)
	);

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int period       = 10,
	parameter int reset_cycles = 3
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// Synchronous reset held for the first few rising edges
	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

//--- tb/nn_sva.sv
`timescale 1ns/1ps

module nn_sva (
	input logic                clk,
	input logic                reset,
	input logic                out_valid,
	input logic                out_ready,
	input nn_cfg_pkg::sample_t out_data
);

	import nn_cfg_pkg::*;

	// Output held under back-pressure
	a_hold_data: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> $stable(out_data))
	else $error("out_data changed while waiting for out_ready");

	a_hold_valid: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid)
	else $error("out_valid dropped before its beat transferred");

	// ReLU leaves no negative result
	a_relu: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> !out_data[sample_width-1])
	else $error("negative out_data 0x%h while out_valid is high", out_data);

endmodule

bind nn_top nn_sva i_sva (
	.clk       (clk),
	.reset     (reset),
	.out_valid (out_valid),
	.out_ready (out_ready),
	.out_data  (out_data)
);

//--- tb/nn_tb.sv
`timescale 1ns/1ps

module nn_tb;

	import nn_cfg_pkg::*;

	localparam int num_vec    = 16;
	localparam int line_len   = 1 + in_len + out_len;
	localparam int max_cycles = num_vec * 200;

	logic    clk;
	logic    reset;
	logic    in_valid;
	logic    in_ready;
	sample_t in_data;
	logic    out_valid;
	logic    out_ready;
	sample_t out_data;

	// Stall flag, inputs and expected outputs of each vector
	sample_t stim_mem [num_vec*line_len];

	int cycles    = 0;
	int out_vec   = 0;
	int out_row   = 0;

	tb_clock #(.period(10), .reset_cycles(3)) i_clock (
		.clk   (clk),
		.reset (reset)
	);

	nn_top i_dut (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_data),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data)
	);

	task automatic abort_run();
		$display("SOME TESTS FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic report_problem(input string msg);
		$display("Error: %s", msg);
		abort_run();
	endtask

	task automatic check_sample(input string name, input sample_t expected, input sample_t actual);
		if (actual !== expected) begin
			$display("[FAIL] %s: expected %h, got %h", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("[FAIL] %s: expected %h, got %h", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			in_valid <= 1'b0;
		end
	endtask

	// Returns on the negedge before the accepting edge
	task automatic send_sample(input sample_t data);
		@(posedge clk);
		in_valid <= 1'b1;
		in_data  <= data;
		@(negedge clk);
		while (in_ready !== 1'b1) begin
			@(negedge clk);
		end
	endtask

	task automatic expect_idle_after_reset();
		int after;
		after = 0;
		@(posedge clk);
		while (after < 2) begin
			@(negedge clk);
			check_flag("in_ready", 1'b1, in_ready);
			check_flag("out_valid", 1'b0, out_valid);
			if (!reset)
				after++;
		end
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("Timeout: only %0d of %0d vectors came out after %0d cycles",
				out_vec, num_vec, cycles);
			abort_run();
		end
	end

	// Random back-pressure only on vectors flagged for it
	always @(posedge clk) begin
		if (reset || out_vec >= num_vec)
			out_ready <= 1'b1;
		else if (stim_mem[out_vec*line_len] != 0)
			out_ready <= 1'($urandom % 2);
		else
			out_ready <= 1'b1;
	end

	always @(negedge clk) begin
		if (!reset && out_valid === 1'b1 && out_ready === 1'b1) begin
			if (out_vec >= num_vec) begin
				report_problem("output beat seen after the last expected vector");
			end else begin
				check_sample($sformatf("out_data v%0d r%0d", out_vec, out_row),
					stim_mem[out_vec*line_len + 1 + in_len + out_row], out_data);
				if (out_row == out_len - 1) begin
					out_row = 0;
					out_vec = out_vec + 1;
				end else begin
					out_row = out_row + 1;
				end
			end
		end
	end

	initial begin
		int gap;
		in_valid  = 1'b0;
		in_data   = '0;
		out_ready = 1'b1;
		void'($urandom(50301));
		$readmemh("tb/nn_stimulus.txt", stim_mem);

		expect_idle_after_reset();

		for (int v = 0; v < num_vec; v++) begin
			for (int e = 0; e < in_len; e++) begin
				gap = int'($urandom % 3);
				idle_cycles(gap);
				send_sample(stim_mem[v*line_len + 1 + e]);
			end
		end
		idle_cycles(1);

		while (out_vec < num_vec) begin
			@(negedge clk);
		end

		// No extra beats after the last vector
		repeat (20) begin
			@(negedge clk);
			check_flag("out_valid", 1'b0, out_valid);
		end
		check_flag("in_ready", 1'b1, in_ready);

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

//--- tb/nn_stimulus.txt
// Columns: stall x0 x1 x2 x3, then y0 to y11 after both layers, all 16-bit hex
// stall 1 makes out_ready toggle randomly while that vector drains
// Unit vectors, zero vector, negative and mixed inputs
0 0001 0000 0000 0000 0000 0000 0000 0013 001c 002a 0000 0000 0000 0012 0000 0000
0 0000 0001 0000 0000 004e 0000 0000 0000 0031 0018 0008 0000 0000 0000 0013 0000
0 0000 0000 0001 0000 0000 0000 000e 0000 0000 000b 0000 0000 001a 0000 0000 0000
0 0000 0000 0000 0001 0004 0000 0000 0041 0061 0035 0012 0000 0000 0000 0000 0001
0 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0 ffff 0000 0000 0000 002e 0014 0008 001e 0046 0008 001c 0000 0000 0000 0000 0000
0 0001 0001 0001 0001 001d 0000 0000 0000 002b 003f 000c 0000 0000 0008 0000 0000
0 0002 0000 0000 ffff 0004 0000 0000 0000 0000 002a 0000 0000 0029 0001 0000 0000
// Layer 2 sums wrap at 16 bits
0 1000 0000 0000 0000 5000 7000 3000 3000 0000 0000 0000 0000 0000 2000 0000 5000
// Same vectors under back-pressure
1 0001 0001 0001 0001 001d 0000 0000 0000 002b 003f 000c 0000 0000 0008 0000 0000
1 0002 0000 0000 ffff 0004 0000 0000 0000 0000 002a 0000 0000 0029 0001 0000 0000
1 0001 0000 0000 0000 0000 0000 0000 0013 001c 002a 0000 0000 0000 0012 0000 0000
1 0000 0000 0000 0001 0004 0000 0000 0041 0061 0035 0012 0000 0000 0000 0000 0001
1 0000 0001 0000 0000 004e 0000 0000 0000 0031 0018 0008 0000 0000 0000 0013 0000
1 ffff 0000 0000 0000 002e 0014 0008 001e 0046 0008 001c 0000 0000 0000 0000 0000
1 1000 0000 0000 0000 5000 7000 3000 3000 0000 0000 0000 0000 0000 2000 0000 5000

//--- project.f
design/nn_cfg_pkg.sv
design/nn_weights_pkg.sv
design/layer_control.sv
design/mac_array.sv
design/fc_layer.sv
design/nn_top.sv
tb/tb_clock.sv
tb/nn_sva.sv
tb/nn_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= nn_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
